//--- logic/fpPkg.sv
`default_nettype none

package fpPkg;

	localparam int ExpBias = 127;
	localparam int ExpMax = 255; // all ones marks infinity.

	typedef logic [7:0] fpExp;
	typedef logic [22:0] fpMant;

	// single-precision word in IEEE field order.
	typedef struct packed
	{
		logic sign;
		fpExp exp;
		fpMant mant;
	} fpWord;

	localparam fpWord fpZero = '0;

endpackage

`default_nettype wire

//--- logic/netPkg.sv
`default_nettype none

package netPkg;

	localparam int InputCount = 8;
	localparam int HiddenCount = 4;
	localparam int OutputCount = 2;

	typedef fpPkg::fpWord [InputCount-1:0] inVec;
	typedef fpPkg::fpWord [HiddenCount-1:0] hiddenVec;
	typedef fpPkg::fpWord [OutputCount-1:0] outVec;

	// the last node comes first and the rightmost word of a row is element 0.
	localparam inVec [HiddenCount-1:0] HiddenWeights = {
		{32'h3E4CCCCD, 32'hBF000000, 32'h3F19999A, 32'hBE99999A,
			32'h3DCCCCCD, 32'hBF333333, 32'h3F400000, 32'hBE800000},
		{32'h3EB33333, 32'hBDCCCCCD, 32'h3F0CCCCD, 32'hBF4CCCCD,
			32'h3E99999A, 32'hBEE66666, 32'h3F266666, 32'hBE4CCCCD},
		{32'hBE3851EC, 32'h3F0F5C29, 32'hBEA3D70A, 32'h3E8F5C29,
			32'hBF1EB852, 32'h3DF5C28F, 32'h3ECCCCCD, 32'hBF051EB8},
		{32'h3F2E147B, 32'hBE6B851F, 32'h3E23D70A, 32'hBEC28F5C,
			32'h3F5C28F6, 32'hBDA3D70A, 32'hBE0F5C29, 32'h3EF0A3D7}
	};

	localparam hiddenVec HiddenBias = {
		32'hBE19999A,
		32'h3E000000,
		32'hBDCCCCCD,
		32'h3D4CCCCD
	};

	localparam hiddenVec [OutputCount-1:0] OutputWeights = {
		{32'h3F0CCCCD, 32'hBEB33333, 32'h3E4CCCCD, 32'hBF19999A},
		{32'hBE99999A, 32'h3F333333, 32'hBF000000, 32'h3EE66666}
	};

	localparam outVec OutputBias = {
		32'h3DCCCCCD,
		32'hBD4CCCCD
	};

endpackage

`default_nettype wire

//--- logic/fpMultiplier.sv
`timescale 1ns/1ps
`default_nettype none

module fpMultiplier (
	input  wire fpPkg::fpWord a,
	input  wire fpPkg::fpWord b,
	output fpPkg::fpWord      product
);

	logic              zeroIn;
	logic              resSign;
	logic [23:0]       sigA;
	logic [23:0]       sigB;
	logic [47:0]       sigProd;
	logic              normBit;
	logic signed [9:0] expSum;
	fpPkg::fpMant      mantOut;

	// a zero exponent covers both zero and denormal operands.
	assign zeroIn = (a.exp == '0) || (b.exp == '0);
	assign resSign = a.sign ^ b.sign;

	assign sigA = {1'b1, a.mant};
	assign sigB = {1'b1, b.mant};
	assign sigProd = sigA * sigB;

	// the product of two normalized significands lies in [1, 4).
	assign normBit = sigProd[47];
	assign mantOut = normBit ? sigProd[46:24] : sigProd[45:23]; // lower bits are dropped.

	assign expSum = 10'(a.exp) + 10'(b.exp) + 10'(normBit) - 10'(fpPkg::ExpBias);

	always_comb
	begin
		if (zeroIn || expSum <= 0)
			product = fpPkg::fpZero;
		else if (expSum >= fpPkg::ExpMax)
		begin
			product.sign = resSign;
			product.exp = fpPkg::fpExp'(fpPkg::ExpMax);
			product.mant = '0;
		end
		else
		begin
			product.sign = resSign;
			product.exp = expSum[7:0];
			product.mant = mantOut;
		end
	end

endmodule

`default_nettype wire

//--- logic/fpAdder.sv
`timescale 1ns/1ps
`default_nettype none

module fpAdder (
	input  wire fpPkg::fpWord a,
	input  wire fpPkg::fpWord b,
	output fpPkg::fpWord      sum
);

	logic              aLarger;
	fpPkg::fpWord      big;
	fpPkg::fpWord      little;
	fpPkg::fpExp       expDiff;
	logic [23:0]       sigBig;
	logic [23:0]       sigSmall;
	logic [24:0]       sigSum;
	logic [4:0]        leadPos;
	logic [4:0]        leftShift;
	logic [23:0]       sigNorm;
	logic signed [9:0] expOut;
	fpPkg::fpMant      mantOut;

	// magnitude order follows from the exponent and fraction fields alone.
	assign aLarger = {a.exp, a.mant} >= {b.exp, b.mant};
	assign big = aLarger ? a : b;
	assign little = aLarger ? b : a;

	assign expDiff = big.exp - little.exp;
	assign sigBig = (big.exp == '0) ? 24'd0 : {1'b1, big.mant};
	assign sigSmall = ((little.exp == '0) ? 24'd0 : {1'b1, little.mant}) >> expDiff;

	// big is never smaller than little, so the difference stays positive.
	assign sigSum = (big.sign == little.sign) ? {1'b0, sigBig} + {1'b0, sigSmall}
		: {1'b0, sigBig} - {1'b0, sigSmall};

	always_comb
	begin
		leadPos = '0;
		for (int i = 0; i < 24; i++)
		begin
			if (sigSum[i])
				leadPos = 5'(i); // the highest set bit wins.
		end
	end

	assign leftShift = 5'd23 - leadPos;
	assign sigNorm = sigSum[23:0] << leftShift;

	always_comb
	begin
		if (sigSum[24])
		begin
			expOut = 10'(big.exp) + 10'd1;
			mantOut = sigSum[23:1];
		end
		else
		begin
			expOut = 10'(big.exp) - 10'(leftShift);
			mantOut = sigNorm[22:0];
		end

		if (sigSum == '0 || expOut <= 0)
			sum = fpPkg::fpZero; // exact cancellation and underflow both give +0.
		else if (expOut >= fpPkg::ExpMax)
		begin
			sum.sign = big.sign;
			sum.exp = fpPkg::fpExp'(fpPkg::ExpMax);
			sum.mant = '0;
		end
		else
		begin
			sum.sign = big.sign;
			sum.exp = expOut[7:0];
			sum.mant = mantOut;
		end
	end

endmodule

`default_nettype wire

//--- logic/neuronNode.sv
`timescale 1ns/1ps
`default_nettype none

module neuronNode #(
	parameter int                          FanIn = 8,
	parameter fpPkg::fpWord [FanIn-1:0] Weights = '0,
	parameter fpPkg::fpWord                Bias = '0,
	parameter bit                          Rectify = 1'b0
) (
	input  wire                             clk,
	input  wire                             rstN,
	input  wire fpPkg::fpWord [FanIn-1:0] activations,
	output fpPkg::fpWord                    result
);

	localparam int Terms = FanIn + 1; // products plus the bias.
	localparam int Levels = $clog2(Terms);

	// number of terms left after the given number of tree levels.
	function automatic int levelTerms(input int level);
		int n;
		n = Terms;
		for (int i = 0; i < level; i++)
			n = (n + 1) / 2;
		return n;
	endfunction

	fpPkg::fpWord tree [Levels+1][Terms];
	fpPkg::fpWord clamped;

	for (genvar i = 0; i < FanIn; i++)
	begin : gMul
		fpMultiplier uMul (
			.a       (activations[i]),
			.b       (Weights[i]),
			.product (tree[0][i])
		);
	end

	assign tree[0][FanIn] = Bias;

	for (genvar lv = 0; lv < Levels; lv++)
	begin : gLevel
		for (genvar j = 0; j < levelTerms(lv + 1); j++)
		begin : gTerm
			if (2 * j + 1 < levelTerms(lv))
			begin : gAdd
				fpAdder uAdd (
					.a   (tree[lv][2*j]),
					.b   (tree[lv][2*j+1]),
					.sum (tree[lv+1][j])
				);
			end
			else
			begin : gPass
				assign tree[lv+1][j] = tree[lv][2*j]; // odd last term moves up unchanged.
			end
		end
	end

	// the sign bit alone decides, so a negative zero clamps as well.
	assign clamped = (Rectify && tree[Levels][0].sign) ? fpPkg::fpZero : tree[Levels][0];

	always_ff @(posedge clk or negedge rstN)
	begin
		if (!rstN)
			result <= fpPkg::fpZero;
		else
			result <= clamped;
	end

endmodule

`default_nettype wire

//--- logic/denseLayer.sv
`timescale 1ns/1ps
`default_nettype none

module denseLayer #(
	parameter int                                      FanIn = 8,
	parameter int                                      Width = 4,
	parameter fpPkg::fpWord [Width-1:0][FanIn-1:0] Weights = '0,
	parameter fpPkg::fpWord [Width-1:0]               Biases = '0,
	parameter bit                                      Rectify = 1'b0
) (
	input  wire                             clk,
	input  wire                             rstN,
	input  wire fpPkg::fpWord [FanIn-1:0] activations,
	output wire fpPkg::fpWord [Width-1:0] results
);

	// row n of the weight table and bias n belong to node n.
	for (genvar n = 0; n < Width; n++)
	begin : gNode
		neuronNode #(
			.FanIn   (FanIn),
			.Weights (Weights[n]),
			.Bias    (Biases[n]),
			.Rectify (Rectify)
		) uNode (
			.clk         (clk),
			.rstN        (rstN),
			.activations (activations), // every node sees the whole input vector.
			.result      (results[n])
		);
	end

endmodule

`default_nettype wire

//--- logic/mlpCore.sv
`timescale 1ns/1ps
`default_nettype none

module mlpCore (
	input  wire                 clk,
	input  wire                 rstN,
	input  wire netPkg::inVec  features,
	output wire netPkg::outVec scores
);

	netPkg::hiddenVec hidden; // registered and rectified hidden activations.

	denseLayer #(
		.FanIn   (netPkg::InputCount),
		.Width   (netPkg::HiddenCount),
		.Weights (netPkg::HiddenWeights),
		.Biases  (netPkg::HiddenBias),
		.Rectify (1'b1)
	) uHidden (
		.clk         (clk),
		.rstN        (rstN),
		.activations (features),
		.results     (hidden)
	);

	// the output layer stays linear.
	denseLayer #(
		.FanIn   (netPkg::HiddenCount),
		.Width   (netPkg::OutputCount),
		.Weights (netPkg::OutputWeights),
		.Biases  (netPkg::OutputBias),
		.Rectify (1'b0)
	) uOutput (
		.clk         (clk),
		.rstN        (rstN),
		.activations (hidden),
		.results     (scores)
	);

endmodule

`default_nettype wire

//--- testbench/fpModel.svh
`ifndef FP_MODEL_SVH
`define FP_MODEL_SVH

localparam int MaxFanIn = netPkg::InputCount;

function automatic fpPkg::fpWord infWord(input logic sign);
	fpPkg::fpWord w;
	w.sign = sign;
	w.exp = 8'hFF;
	w.mant = '0;
	return w;
endfunction

// multiply by the simplified rules, with any zero exponent reading as zero.
function automatic fpPkg::fpWord refMul(input fpPkg::fpWord a, input fpPkg::fpWord b);
	logic [47:0] p;
	int e;
	fpPkg::fpWord r;
	if (a.exp == 0 || b.exp == 0)
		return fpPkg::fpZero;
	p = 48'({1'b1, a.mant}) * 48'({1'b1, b.mant});
	e = int'(a.exp) + int'(b.exp) - fpPkg::ExpBias;
	r.sign = a.sign ^ b.sign;
	if (p[47])
	begin
		e = e + 1;
		r.mant = p[46:24];
	end
	else
		r.mant = p[45:23];
	if (e <= 0)
		return fpPkg::fpZero;
	if (e >= fpPkg::ExpMax)
		return infWord(r.sign);
	r.exp = e[7:0];
	return r;
endfunction

function automatic fpPkg::fpWord refAdd(input fpPkg::fpWord a, input fpPkg::fpWord b);
	fpPkg::fpWord hi;
	fpPkg::fpWord lo;
	fpPkg::fpWord r;
	int sigHi;
	int sigLo;
	int diff;
	int s;
	int e;
	if ({a.exp, a.mant} >= {b.exp, b.mant})
	begin
		hi = a;
		lo = b;
	end
	else
	begin
		hi = b;
		lo = a;
	end
	sigHi = (hi.exp == 0) ? 0 : int'({1'b1, hi.mant});
	sigLo = (lo.exp == 0) ? 0 : int'({1'b1, lo.mant});
	diff = int'(hi.exp) - int'(lo.exp);
	sigLo = (diff >= 24) ? 0 : (sigLo >> diff); // shifted-out bits are lost.
	s = (hi.sign == lo.sign) ? sigHi + sigLo : sigHi - sigLo;
	if (s == 0)
		return fpPkg::fpZero;
	e = int'(hi.exp);
	if (s >= (1 << 24))
	begin
		s = s >> 1;
		e = e + 1;
	end
	while (s < (1 << 23))
	begin
		s = s << 1;
		e = e - 1;
	end
	if (e <= 0)
		return fpPkg::fpZero;
	if (e >= fpPkg::ExpMax)
		return infWord(hi.sign);
	r.sign = hi.sign;
	r.exp = e[7:0];
	r.mant = s[22:0];
	return r;
endfunction

// products in input order then the bias, reduced pairwise level by level.
function automatic fpPkg::fpWord refNode(input fpPkg::fpWord [MaxFanIn-1:0] acts,
	input fpPkg::fpWord [MaxFanIn-1:0] weights, input fpPkg::fpWord bias,
	input int fanIn, input bit rectify);
	fpPkg::fpWord terms [MaxFanIn+1];
	int count;
	for (int i = 0; i < fanIn; i++)
		terms[i] = refMul(acts[i], weights[i]);
	terms[fanIn] = bias;
	count = fanIn + 1;
	while (count > 1)
	begin
		for (int j = 0; 2 * j < count; j++)
			terms[j] = (2 * j + 1 < count) ? refAdd(terms[2*j], terms[2*j+1]) : terms[2*j];
		count = (count + 1) / 2;
	end
	if (rectify && terms[0].sign)
		return fpPkg::fpZero;
	return terms[0];
endfunction

function automatic netPkg::outVec refNetwork(input netPkg::inVec f);
	netPkg::hiddenVec h;
	netPkg::outVec o;
	fpPkg::fpWord [MaxFanIn-1:0] acts;
	fpPkg::fpWord [MaxFanIn-1:0] w;
	for (int n = 0; n < netPkg::HiddenCount; n++)
		h[n] = refNode(f, netPkg::HiddenWeights[n], netPkg::HiddenBias[n],
			netPkg::InputCount, 1'b1);
	for (int n = 0; n < netPkg::OutputCount; n++)
	begin
		acts = '0;
		w = '0;
		for (int i = 0; i < netPkg::HiddenCount; i++)
		begin
			acts[i] = h[i];
			w[i] = netPkg::OutputWeights[n][i];
		end
		o[n] = refNode(acts, w, netPkg::OutputBias[n], netPkg::HiddenCount, 1'b0);
	end
	return o;
endfunction

`endif

//--- testbench/mlpCoreTb.sv
`timescale 1ns/1ps
`default_nettype none

module mlpCoreTb;

	localparam int ResetCycles = 5;
	localparam int RandomCount = 60;
	localparam int CornerCount = 6;
	localparam int VectorCount = 1 + RandomCount + netPkg::HiddenCount + CornerCount;
	localparam int CycleLimit = ResetCycles + VectorCount + 20;

	logic          clk;
	logic          rstN;
	netPkg::inVec  features;
	netPkg::outVec scores;

	netPkg::outVec expQ [$];
	int            dueQ [$]; // cycle count at which each vector was driven.
	int            cycleCount;
	netPkg::outVec expected;
	netPkg::inVec  vec;

	`include "fpModel.svh"

	mlpCore u_dut (
		.clk      (clk),
		.rstN     (rstN),
		.features (features),
		.scores   (scores)
	);

	always #10 clk = ~clk;

	task automatic checkValue(input fpPkg::fpWord actual, input fpPkg::fpWord expectedWord,
		input int node, input string what);
		if (actual !== expectedWord)
		begin
			$display("[FAIL] %0t: %s node %0d got %h, expected %h", $time, what, node,
				32'(actual), 32'(expectedWord));
			$display("TEST RESULT: FAIL");
			$fatal(1, "%s mismatch on node %0d", what, node);
		end
	endtask

	function automatic fpPkg::fpWord randomWord(input int expLo, input int expHi);
		fpPkg::fpWord w;
		w.sign = 1'($urandom_range(1, 0));
		w.exp = 8'($urandom_range(expHi, expLo));
		w.mant = 23'($urandom);
		return w;
	endfunction

	task automatic applyVector(input netPkg::inVec v);
		@(posedge clk);
		features <= v;
		expQ.push_back(refNetwork(v));
		dueQ.push_back(cycleCount);
	endtask

	always @(posedge clk)
	begin
		cycleCount <= cycleCount + 1;
		if (cycleCount >= CycleLimit)
		begin
			$display("timeout after %0d cycles with %0d results outstanding",
				cycleCount, expQ.size());
			$display("TEST RESULT: FAIL");
			$fatal(1, "simulation did not finish in time");
		end
	end

	// driven at count c, sampled one edge later, visible after the second edge.
	always @(negedge clk)
	begin
		if (dueQ.size() > 0 && dueQ[0] + 3 == cycleCount)
		begin
			expected = expQ.pop_front();
			void'(dueQ.pop_front());
			for (int n = 0; n < netPkg::OutputCount; n++)
				checkValue(scores[n], expected[n], n, "score");
		end
	end

	initial
	begin
		void'($urandom(32'h5851));
		clk = 1'b0;
		rstN = 1'b0;
		features = '0;
		cycleCount = 0;

		repeat (ResetCycles)
		begin
			@(negedge clk);
			for (int n = 0; n < netPkg::OutputCount; n++)
				checkValue(scores[n], fpPkg::fpZero, n, "reset");
		end
		@(posedge clk);
		rstN <= 1'b1;
		@(negedge clk);
		for (int n = 0; n < netPkg::OutputCount; n++)
			checkValue(scores[n], fpPkg::fpZero, n, "idle");

		applyVector('0); // bias path only.

		repeat (RandomCount)
		begin
			for (int i = 0; i < netPkg::InputCount; i++)
				vec[i] = randomWord(112, 140);
			applyVector(vec);
		end

		// every product of node n turns negative.
		for (int n = 0; n < netPkg::HiddenCount; n++)
		begin
			for (int i = 0; i < netPkg::InputCount; i++)
			begin
				vec[i] = randomWord(127, 130);
				vec[i].sign = ~netPkg::HiddenWeights[n][i].sign;
			end
			applyVector(vec);
		end

		for (int i = 0; i < netPkg::InputCount; i++)
			vec[i] = randomWord(0, 0);
		applyVector(vec);
		for (int i = 0; i < netPkg::InputCount; i++)
			vec[i] = fpPkg::fpWord'(32'h80000000); // negative zero features.
		applyVector(vec);

		// node 0 sees only positive products here, so its sum overflows.
		for (int i = 0; i < netPkg::InputCount; i++)
		begin
			vec[i] = randomWord(254, 254);
			vec[i].sign = netPkg::HiddenWeights[0][i].sign;
		end
		applyVector(vec);
		for (int i = 0; i < netPkg::InputCount; i++)
			vec[i] = randomWord(250, 254);
		applyVector(vec);

		repeat (2)
		begin
			for (int i = 0; i < netPkg::InputCount; i++)
				vec[i] = randomWord(1, 4);
			applyVector(vec);
		end

		while (expQ.size() != 0)
			@(negedge clk);

		$display("TEST RESULT: PASS");
		$finish;
	end

endmodule

`default_nettype wire

//--- mlpCore.f
+incdir+testbench
logic/fpPkg.sv
logic/netPkg.sv
logic/fpMultiplier.sv
logic/fpAdder.sv
logic/neuronNode.sv
logic/denseLayer.sv
logic/mlpCore.sv
testbench/mlpCoreTb.sv

//--- Bender.yml
package:
  name: mlpCore

sources:
  - files:
      - logic/fpPkg.sv
      - logic/netPkg.sv
      - logic/fpMultiplier.sv
      - logic/fpAdder.sv
      - logic/neuronNode.sv
      - logic/denseLayer.sv
      - logic/mlpCore.sv

  - target: test
    include_dirs:
      - testbench
    files:
      - testbench/mlpCoreTb.sv
